// ==== list.f ====
design/dcu_tag_pkg.sv
design/dcu_tag_eccenc.sv
design/dcu_eccdec32.sv
design/dcu_eccdec_tag.sv
design/dcu_tag_ram.sv
design/dcu_tag_cmd_dec.sv
design/dcu_tag_hit_result.sv
design/dcu_tag_top.sv
testbench/tb_clk_gen.sv
testbench/tb_dcu_tag.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcu_tag
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_dcu_tag.sv ====
// Directed tests of the ECC tag store against a per-way model; run as the simulation top.
`timescale 1ns/1ps
`default_nettype none

module tb_dcu_tag
    import dcu_tag_pkg::*;
();

    logic                  core_clk;
    logic                  rst_n;
    logic                  req_valid;
    tag_op_e               req_op;
    logic [31:0]           req_addr;
    logic [WAY_AW-1:0]     req_way;
    line_state_e           req_state;
    logic [TAG_RAM_CW-1:0] req_inject;
    logic                  rsp_valid;
    logic                  rsp_hit;
    logic [WAY_AW-1:0]     rsp_way;
    line_state_e           rsp_state;
    logic                  rsp_sec;
    logic                  rsp_ded;

    logic [TAG_W-1:0] model_tag   [NUM_SETS][DCACHE_WAY];
    line_state_e      model_state [NUM_SETS][DCACHE_WAY];
    int               model_err   [NUM_SETS][DCACHE_WAY]; // Flipped bits.

    int                exp_due[$];
    logic              exp_hit[$];
    logic [WAY_AW-1:0] exp_way[$];
    line_state_e       exp_state[$];
    logic              exp_sec[$];
    logic              exp_ded[$];

    int neg_cnt  = 0;
    int err_cnt  = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int seed     = 56;

    tb_clk_gen u_clk_gen (.clk(core_clk));

    dcu_tag_top dcu_tag_top_i (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_way    (req_way),
        .req_state  (req_state),
        .req_inject (req_inject),
        .rsp_valid  (rsp_valid),
        .rsp_hit    (rsp_hit),
        .rsp_way    (rsp_way),
        .rsp_state  (rsp_state),
        .rsp_sec    (rsp_sec),
        .rsp_ded    (rsp_ded)
    );

    function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] tag,
                                              input logic [SET_AW-1:0] idx);
        return {tag, idx, 6'b0};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Each expected response falls due on the third falling edge after its lookup.
    task automatic watch_responses();
        forever begin
            @(negedge core_clk);
            neg_cnt++;
            if (exp_due.size() != 0 && exp_due[0] == neg_cnt) begin
                if (rsp_valid !== 1'b1) begin
                    $display("Response missing: rsp_valid low two cycles after a lookup");
                    err_cnt++;
                end else begin
                    check_val("rsp_hit", 32'(rsp_hit), 32'(exp_hit[0]));
                    check_val("rsp_way", 32'(rsp_way), 32'(exp_way[0]));
                    check_val("rsp_state", 32'(rsp_state), 32'(exp_state[0]));
                    check_val("rsp_sec", 32'(rsp_sec), 32'(exp_sec[0]));
                    check_val("rsp_ded", 32'(rsp_ded), 32'(exp_ded[0]));
                end
                void'(exp_due.pop_front());
                void'(exp_hit.pop_front());
                void'(exp_way.pop_front());
                void'(exp_state.pop_front());
                void'(exp_sec.pop_front());
                void'(exp_ded.pop_front());
            end else if (rsp_valid === 1'b1) begin
                $display("Unexpected response: rsp_valid high with no lookup two cycles before");
                err_cnt++;
            end
        end
    endtask

    task automatic drive_idle();
        @(posedge core_clk);
        req_valid  <= 1'b0;
        req_op     <= TAG_OP_NONE;
        req_inject <= '0;
    endtask

    task automatic do_fill(input logic [TAG_W-1:0] tag, input logic [SET_AW-1:0] idx,
                           input logic [WAY_AW-1:0] way, input line_state_e st,
                           input logic [TAG_RAM_CW-1:0] inject);
        @(posedge core_clk);
        req_valid  <= 1'b1;
        req_op     <= TAG_OP_FILL;
        req_addr   <= make_addr(tag, idx);
        req_way    <= way;
        req_state  <= st;
        req_inject <= inject;
        model_tag[idx][way]   = tag;
        model_state[idx][way] = st;
        model_err[idx][way]   = $countones(inject);
    endtask

    task automatic do_inval(input logic [SET_AW-1:0] idx, input logic [WAY_AW-1:0] way);
        @(posedge core_clk);
        req_valid  <= 1'b1;
        req_op     <= TAG_OP_INVAL;
        req_addr   <= make_addr(TAG_W'(22'h15555), idx);
        req_way    <= way;
        req_state  <= LS_MODIFIED;
        req_inject <= TAG_RAM_CW'(3); // Mask must be ignored.
        model_tag[idx][way]   = '0;
        model_state[idx][way] = LS_INVALID;
        model_err[idx][way]   = 0;
    endtask

    // Expected response from the model: lowest valid match wins, any ded kills the hit.
    task automatic do_lookup(input logic [31:0] addr);
        logic [SET_AW-1:0] idx;
        logic [TAG_W-1:0]  tag;
        logic              hit;
        logic [WAY_AW-1:0] way;
        line_state_e       st;
        logic              sec;
        logic              ded;
        idx = addr[SET_LSB +: SET_AW];
        tag = addr[TAG_LSB +: TAG_W];
        hit = 1'b0;
        way = '0;
        st  = LS_INVALID;
        sec = 1'b0;
        ded = 1'b0;
        for (int w = 0; w < DCACHE_WAY; w++) begin
            if (model_err[idx][w] == 1) sec = 1'b1;
            if (model_err[idx][w] >= 2) ded = 1'b1;
            if (!hit && model_state[idx][w] != LS_INVALID && model_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = WAY_AW'(w);
                st  = model_state[idx][w];
            end
        end
        if (ded) begin
            hit = 1'b0;
            way = '0;
            st  = LS_INVALID;
        end
        @(posedge core_clk);
        req_valid  <= 1'b1;
        req_op     <= TAG_OP_LOOKUP;
        req_addr   <= addr;
        req_inject <= '0;
        exp_due.push_back(neg_cnt + 3);
        exp_hit.push_back(hit);
        exp_way.push_back(way);
        exp_state.push_back(st);
        exp_sec.push_back(sec);
        exp_ded.push_back(ded);
    endtask

    task automatic end_test(input string name, input int err_before);
        while (exp_due.size() != 0) @(negedge core_clk);
        repeat (2) @(negedge core_clk); // Catch a stray late response.
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s with %0d errors", name, err_cnt - err_before);
        end
    endtask

    task automatic test_reset_miss();
        repeat (3) drive_idle(); // Response stays quiet before any lookup.
        do_lookup(make_addr('0, 4'd0));
        do_lookup(make_addr(TAG_W'(22'h3a5a5), 4'd7));
        do_lookup(make_addr(TAG_W'($random(seed)), SET_AW'($random(seed))));
        drive_idle();
    endtask

    task automatic test_fill_hit();
        do_fill(TAG_W'(22'h12345), 4'd5, 2'd2, LS_MODIFIED, '0);
        do_lookup(make_addr(TAG_W'(22'h12345), 4'd5));
        do_lookup(make_addr(TAG_W'(22'h12344), 4'd5));
        drive_idle();
    endtask

    task automatic test_inval_miss();
        do_inval(4'd5, 2'd2);
        do_lookup(make_addr(TAG_W'(22'h12345), 4'd5));
        drive_idle();
    endtask

    task automatic test_single_fault();
        int bits[8] = '{0, 9, 21, 22, 23, 24, 29, 30};
        for (int i = 0; i < 8; i++) begin
            do_fill(TAG_W'(22'h2f0c1), 4'd5, 2'd1, LS_EXCLUSIVE, TAG_RAM_CW'(1) << bits[i]);
            do_lookup(make_addr(TAG_W'(22'h2f0c1), 4'd5));
        end
        drive_idle();
    endtask

    task automatic test_double_fault();
        logic [TAG_RAM_CW-1:0] mask;
        do_fill(TAG_W'(22'h2aaaa), 4'd9, 2'd0, LS_SHARED, '0);
        for (int w = 1; w < DCACHE_WAY; w++) begin
            mask = (TAG_RAM_CW'(1) << w) | (TAG_RAM_CW'(1) << (TAG_RAM_DW + w));
            do_fill(TAG_W'(22'h01234), 4'd9, WAY_AW'(w), LS_MODIFIED, mask);
            do_lookup(make_addr(TAG_W'(22'h2aaaa), 4'd9));
            do_inval(4'd9, WAY_AW'(w));
            do_lookup(make_addr(TAG_W'(22'h2aaaa), 4'd9)); // Clean set hits again.
        end
        drive_idle();
    endtask

    task automatic test_random_traffic();
        logic [SET_AW-1:0] sets [4];
        logic [SET_AW-1:0] idx;
        logic [WAY_AW-1:0] way;
        logic [TAG_W-1:0]  tag;
        for (int i = 0; i < 4; i++) begin
            sets[i] = SET_AW'($random(seed));
            for (int w = 0; w < DCACHE_WAY; w++) begin
                do_fill(TAG_W'($random(seed)), sets[i], WAY_AW'(w),
                        line_state_e'(2'($random(seed))), '0);
            end
        end
        for (int n = 0; n < 24; n++) begin
            idx = sets[2'($random(seed))];
            way = WAY_AW'($random(seed));
            tag = (($random(seed) & 1) != 0) ? model_tag[idx][way] : TAG_W'($random(seed));
            do_lookup(make_addr(tag, idx)); // Back to back.
        end
        drive_idle();
    endtask

    initial begin
        int err_before;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_op     = TAG_OP_NONE;
        req_addr   = '0;
        req_way    = '0;
        req_state  = LS_INVALID;
        req_inject = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < DCACHE_WAY; w++) begin
                model_tag[s][w]   = '0;
                model_state[s][w] = LS_INVALID;
                model_err[s][w]   = 0;
            end
        end
        fork
            watch_responses();
        join_none
        repeat (10) @(posedge core_clk);
        rst_n <= 1'b1;

        err_before = err_cnt;
        test_reset_miss();
        end_test("reset_miss", err_before);
        err_before = err_cnt;
        test_fill_hit();
        end_test("fill_hit", err_before);
        err_before = err_cnt;
        test_inval_miss();
        end_test("inval_miss", err_before);
        err_before = err_cnt;
        test_single_fault();
        end_test("single_fault", err_before);
        err_before = err_cnt;
        test_double_fault();
        end_test("double_fault", err_before);
        err_before = err_cnt;
        test_random_traffic();
        end_test("random_traffic", err_before);

        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Generous bound over the whole run.
    initial begin
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < 2000) begin
            @(posedge core_clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within 2000 cycles");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
// Free-running core clock for the tag store testbench, 40 ns period.
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // Half period.
    end

endmodule

`default_nettype wire

// ==== design/dcu_tag_top.sv ====
// Top of the ECC-protected tag store, linking decode, tag RAM, ECC check and result.
`timescale 1ns/1ps
`default_nettype none

module dcu_tag_top
    import dcu_tag_pkg::*;
(
    input  wire logic                  core_clk,
    input  wire logic                  rst_n,
    input  wire logic                  req_valid,
    input  wire tag_op_e               req_op,
    input  wire logic [31:0]           req_addr,
    input  wire logic [WAY_AW-1:0]     req_way,
    input  wire line_state_e           req_state,
    input  wire logic [TAG_RAM_CW-1:0] req_inject,
    output logic                       rsp_valid,
    output logic                       rsp_hit,
    output logic      [WAY_AW-1:0]     rsp_way,
    output line_state_e                rsp_state,
    output logic                       rsp_sec,
    output logic                       rsp_ded
);

    logic                                  ram_rd_en;
    logic                                  ram_wr_en;
    logic [WAY_AW-1:0]                     ram_wr_way;
    logic [SET_AW-1:0]                     ram_set;
    logic [TAG_RAM_CW-1:0]                 ram_wr_codeword;
    logic                                  lkp_valid;
    logic [TAG_W-1:0]                      lkp_tag;
    logic                                  rd_valid;
    logic [DCACHE_WAY-1:0][TAG_RAM_CW-1:0] rd_codeword;
    logic [DCACHE_WAY-1:0][TAG_RAM_DW-1:0] tag_corrdata;
    logic [DCACHE_WAY-1:0][1:0]            tag_error;

    dcu_tag_cmd_dec u_cmd_dec (
        .core_clk, .rst_n, .req_valid, .req_op, .req_addr, .req_way, .req_state,
        .req_inject, .ram_rd_en, .ram_wr_en, .ram_wr_way, .ram_set, .ram_wr_codeword,
        .lkp_valid, .lkp_tag
    );

    dcu_tag_ram u_tag_ram (
        .core_clk, .rst_n, .ram_rd_en, .ram_wr_en, .ram_wr_way, .ram_set,
        .ram_wr_codeword, .rd_valid, .rd_codeword
    );

    dcu_eccdec_tag u_eccdec_tag (
        .rd_valid, .rd_codeword, .tag_corrdata, .tag_error
    );

    dcu_tag_hit_result u_hit_result (
        .core_clk, .rst_n, .lkp_valid, .lkp_tag, .tag_corrdata, .tag_error,
        .rsp_valid, .rsp_hit, .rsp_way, .rsp_state, .rsp_sec, .rsp_ded
    );

endmodule

`default_nettype wire

// ==== design/dcu_tag_hit_result.sv ====
// Tag compare over all ways, lowest-way hit select, error summary and registered response.
`timescale 1ns/1ps
`default_nettype none

module dcu_tag_hit_result
    import dcu_tag_pkg::*;
(
    input  wire logic                                  core_clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  lkp_valid,
    input  wire logic [TAG_W-1:0]                      lkp_tag,
    input  wire logic [DCACHE_WAY-1:0][TAG_RAM_DW-1:0] tag_corrdata,
    input  wire logic [DCACHE_WAY-1:0][1:0]            tag_error,
    output logic                                       rsp_valid,
    output logic                                       rsp_hit,
    output logic      [WAY_AW-1:0]                     rsp_way,
    output line_state_e                                rsp_state,
    output logic                                       rsp_sec,
    output logic                                       rsp_ded
);

    logic        hit_c;
    logic [WAY_AW-1:0] way_c;
    line_state_e state_c;
    line_state_e way_state;
    logic        sec_c;
    logic        ded_c;

    always_comb begin
        hit_c   = 1'b0;
        way_c   = '0;
        state_c = LS_INVALID;
        sec_c   = 1'b0;
        ded_c   = 1'b0;
        way_state = LS_INVALID;
        // Walk down so the lowest match is kept.
        for (int w = DCACHE_WAY - 1; w >= 0; w--) begin
            sec_c     = sec_c | tag_error[w][0];
            ded_c     = ded_c | tag_error[w][1];
            way_state = line_state_e'(tag_corrdata[w][TAG_RAM_DW-1 -: 2]);
            if (way_state != LS_INVALID && tag_corrdata[w][TAG_W-1:0] == lkp_tag) begin
                hit_c   = 1'b1;
                way_c   = WAY_AW'(w);
                state_c = way_state;
            end
        end
        if (ded_c) begin // Requester must replay.
            hit_c   = 1'b0;
            way_c   = '0;
            state_c = LS_INVALID;
        end
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_hit   <= 1'b0;
            rsp_sec   <= 1'b0;
            rsp_ded   <= 1'b0;
        end else begin
            rsp_valid <= lkp_valid;
            rsp_hit   <= lkp_valid & hit_c;
            rsp_sec   <= lkp_valid & sec_c;
            rsp_ded   <= lkp_valid & ded_c;
        end
    end

    always_ff @(posedge core_clk) begin
        rsp_way   <= way_c;
        rsp_state <= state_c;
    end

    // ECC flags only arrive alongside a staged lookup.
    a_err_with_lkp: assert property (
        @(posedge core_clk) disable iff (!rst_n) !lkp_valid |-> tag_error == '0
    );

endmodule

`default_nettype wire

// ==== design/dcu_tag_cmd_dec.sv ====
// Request decode into tag RAM strobes, encoded write codeword and the staged lookup tag.
`timescale 1ns/1ps
`default_nettype none

module dcu_tag_cmd_dec
    import dcu_tag_pkg::*;
(
    input  wire logic                  core_clk,
    input  wire logic                  rst_n,
    input  wire logic                  req_valid,
    input  wire tag_op_e               req_op,
    input  wire logic [31:0]           req_addr,
    input  wire logic [WAY_AW-1:0]     req_way,
    input  wire line_state_e           req_state,
    input  wire logic [TAG_RAM_CW-1:0] req_inject,
    output logic                       ram_rd_en,
    output logic                       ram_wr_en,
    output logic      [WAY_AW-1:0]     ram_wr_way,
    output logic      [SET_AW-1:0]     ram_set,
    output logic      [TAG_RAM_CW-1:0] ram_wr_codeword,
    output logic                       lkp_valid,
    output logic      [TAG_W-1:0]      lkp_tag
);

    logic                  is_fill;
    logic [TAG_RAM_DW-1:0] entry;
    logic [PW-1:0]         parity;

    assign is_fill    = req_valid && (req_op == TAG_OP_FILL);
    assign ram_rd_en  = req_valid && (req_op == TAG_OP_LOOKUP);
    assign ram_wr_en  = is_fill || (req_valid && (req_op == TAG_OP_INVAL));
    assign ram_wr_way = req_way;
    assign ram_set    = req_addr[SET_LSB +: SET_AW];

    // Invalidate stores a zero tag.
    assign entry = is_fill ? {req_state, req_addr[TAG_LSB +: TAG_W]} : {LS_INVALID, {TAG_W{1'b0}}};

    dcu_tag_eccenc u_eccenc (
        .data   ({{(DW - TAG_RAM_DW){1'b0}}, entry}),
        .parity (parity)
    );

    assign ram_wr_codeword = {parity, entry} ^ (is_fill ? req_inject : '0); // Fault injection.

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            lkp_valid <= 1'b0;
        end else begin
            lkp_valid <= ram_rd_en;
        end
    end

    always_ff @(posedge core_clk) begin
        lkp_tag <= req_addr[TAG_LSB +: TAG_W];
    end

    a_req_op_known: assert property (
        @(posedge core_clk) disable iff (!rst_n) req_valid |-> req_op != TAG_OP_NONE
    );

endmodule

`default_nettype wire

// ==== design/dcu_tag_ram.sv ====
// Flop-based tag array, one-way write and registered full-set read.
`timescale 1ns/1ps
`default_nettype none

module dcu_tag_ram
    import dcu_tag_pkg::*;
(
    input  wire logic                                  core_clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  ram_rd_en,
    input  wire logic                                  ram_wr_en,
    input  wire logic [WAY_AW-1:0]                     ram_wr_way,
    input  wire logic [SET_AW-1:0]                     ram_set,
    input  wire logic [TAG_RAM_CW-1:0]                 ram_wr_codeword,
    output logic                                       rd_valid,
    output logic      [DCACHE_WAY-1:0][TAG_RAM_CW-1:0] rd_codeword
);

    logic [DCACHE_WAY-1:0][TAG_RAM_CW-1:0] mem [NUM_SETS];

    // Zero is a clean invalid codeword.
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                mem[s] <= '0;
            end
        end else if (ram_wr_en) begin
            mem[ram_set][ram_wr_way] <= ram_wr_codeword;
        end
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= ram_rd_en;
        end
    end

    always_ff @(posedge core_clk) begin
        if (ram_rd_en) rd_codeword <= mem[ram_set];
    end

endmodule

`default_nettype wire

// ==== design/dcu_eccdec_tag.sv ====
// ECC check of every way read from the tag RAM, returning corrected entries and error flags.
`timescale 1ns/1ps
`default_nettype none

module dcu_eccdec_tag
    import dcu_tag_pkg::*;
(
    input  wire logic                                  rd_valid,
    input  wire logic [DCACHE_WAY-1:0][TAG_RAM_CW-1:0] rd_codeword,
    output logic      [DCACHE_WAY-1:0][TAG_RAM_DW-1:0] tag_corrdata,
    output logic      [DCACHE_WAY-1:0][1:0]            tag_error
);

    genvar w;

    generate
        for (w = 0; w < DCACHE_WAY; w++) begin : gen_way
            logic [DW-1:0] data_ze;
            logic [PW-1:0] par;
            logic [DW-1:0] dout;

            assign data_ze = {{(DW - TAG_RAM_DW){1'b0}}, rd_codeword[w][TAG_RAM_DW-1:0]};
            assign par     = rd_codeword[w][TAG_RAM_DW +: PW];

            dcu_eccdec32 u_eccdec (
                .data     (data_ze),
                .parin    (par),
                .check_en (rd_valid),
                .dataout  (dout),
                .sec      (tag_error[w][0]),
                .ded      (tag_error[w][1])
            );

            // Upper bits are the zero padding.
            assign tag_corrdata[w] = dout[TAG_RAM_DW-1:0];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== design/dcu_eccdec32.sv ====
// SECDED check and single-bit correction of one 32-bit data word with 7 check bits.
`timescale 1ns/1ps
`default_nettype none

module dcu_eccdec32
    import dcu_tag_pkg::*;
(
    input  wire logic [DW-1:0] data,
    input  wire logic [PW-1:0] parin,
    input  wire logic          check_en,
    output logic      [DW-1:0] dataout,
    output logic               sec,
    output logic               ded
);

    logic [PW-2:0] syn;
    logic          odd;
    logic [DW-1:0] fix;

    always_comb begin
        syn = parin[PW-2:0];
        for (int i = 0; i < DW; i++) begin
            for (int k = 0; k < PW - 1; k++) begin
                if (((ecc_pos(i) >> k) & 1) != 0) begin
                    syn[k] = syn[k] ^ data[i];
                end
            end
        end
    end

    assign odd = ^{data, parin}; // Odd weight error.

    // Syndrome points at the flipped bit; check-bit slots match no data bit.
    always_comb begin
        fix = '0;
        for (int i = 0; i < DW; i++) begin
            fix[i] = (int'(syn) == ecc_pos(i));
        end
    end

    assign sec     = check_en & odd;
    assign ded     = check_en & ~odd & (|syn);
    assign dataout = check_en ? (data ^ (odd ? fix : '0)) : '0;

endmodule

`default_nettype wire

// ==== design/dcu_tag_eccenc.sv ====
// SECDED encoder for a 32-bit word, used to build tag codewords on fill and invalidate.
`timescale 1ns/1ps
`default_nettype none

module dcu_tag_eccenc
    import dcu_tag_pkg::*;
(
    input  wire logic [DW-1:0] data,
    output logic      [PW-1:0] parity
);

    logic [PW-2:0] chk;

    always_comb begin
        chk = '0;
        for (int i = 0; i < DW; i++) begin
            for (int k = 0; k < PW - 1; k++) begin
                if (((ecc_pos(i) >> k) & 1) != 0) begin
                    chk[k] = chk[k] ^ data[i];
                end
            end
        end
    end

    // Overall parity covers data and Hamming bits.
    assign parity = {^{data, chk}, chk};

endmodule

`default_nettype wire

// ==== design/dcu_tag_pkg.sv ====
// Shared widths, counts, enums and the SECDED bit map for the data cache tag store.
`default_nettype none

package dcu_tag_pkg;

    localparam int DCACHE_WAY = 4;
    localparam int SET_AW     = 4;
    localparam int NUM_SETS   = 1 << SET_AW;
    localparam int WAY_AW     = 2;
    localparam int TAG_W      = 22;
    localparam int TAG_LSB    = 10;  // Address bits 31:10.
    localparam int SET_LSB    = 6;   // Address bits 9:6.
    localparam int TAG_RAM_DW = 24;  // {state, tag}.
    localparam int PW         = 7;
    localparam int DW         = 32;
    localparam int TAG_RAM_CW = TAG_RAM_DW + PW;

    typedef enum logic [1:0] {
        TAG_OP_NONE   = 2'd0,
        TAG_OP_LOOKUP = 2'd1,
        TAG_OP_FILL   = 2'd2,
        TAG_OP_INVAL  = 2'd3
    } tag_op_e;

    typedef enum logic [1:0] {
        LS_INVALID   = 2'd0,
        LS_SHARED    = 2'd1,
        LS_EXCLUSIVE = 2'd2,
        LS_MODIFIED  = 2'd3
    } line_state_e;

    // Hamming position of data bit idx, skipping the power-of-two check slots.
    function automatic int ecc_pos(input int idx);
        int pos;
        int cnt;
        pos = 0;
        cnt = 0;
        for (int p = 3; p < 64; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) pos = p;
                cnt++;
            end
        end
        return pos;
    endfunction

endpackage

`default_nettype wire
